// File: verilog/cam_size_pkg.sv
// cam geometry package, default word and address sizes and the counts derived from them
package cam_size_pkg;

    // data word width in bits
    localparam int DATA_W = 24;

    // entry address width
    localparam int ADDR_W = 6;

    // entries held by one search cluster
    localparam int CLUSTER_SIZE = 16;

    // total entries in the data ram and the tag array
    localparam int DEPTH = 1 << ADDR_W;

    // must divide evenly
    localparam int N_CLUSTERS = DEPTH / CLUSTER_SIZE;

endpackage

// File: verilog/cam_tag_pkg.sv
// cam tag layout package, places the tag field in the top bits of a data word
package cam_tag_pkg;

    import cam_size_pkg::*;

    // tag width in bits
    localparam int TAG_W = 16;

    // tag occupies data[DATA_W-1:TAG_LSB]
    localparam int TAG_LSB = DATA_W - TAG_W;

endpackage

// File: verilog/cam_write_port.sv
// cam write port that registers requests, holds the data ram and broadcasts tag writes
`timescale 1ns/1ns

module cam_write_port
    import cam_size_pkg::*;
    import cam_tag_pkg::*;
#(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W,
    parameter int tag_w  = TAG_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ram_we,
    input  logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_din,
    input  logic [tag_w-1:0]  cam_tag,
    output logic [data_w-1:0] ram_dout,
    output logic              tag_wr,
    output logic [addr_w-1:0] tag_wr_addr,
    output logic [tag_w-1:0]  tag_wr_tag,
    output logic [tag_w-1:0]  search_tag
);

    localparam int depth = 1 << addr_w;

    logic [data_w-1:0] mem [depth];

    logic              we_q;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] din_q;
    logic [tag_w-1:0]  cam_tag_q;

    // write strobe is the only control bit of the input stage
    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ram_we;
        end
    end

    always_ff @(posedge clk) begin
        addr_q    <= ram_addr;
        din_q     <= ram_din;
        cam_tag_q <= cam_tag;
    end

    // data ram reads before it writes on the registered address
    always_ff @(posedge clk) begin
        if (we_q) begin
            mem[addr_q] <= din_q;
        end
        ram_dout <= mem[addr_q];
    end

    // every cluster decodes its own range from the broadcast
    assign tag_wr      = we_q;
    assign tag_wr_addr = addr_q;
    assign tag_wr_tag  = din_q[data_w-1 -: tag_w];
    assign search_tag  = cam_tag_q;

    // an unknown strobe would corrupt both the ram and the valid bits
    a_we_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(ram_we)
    ) else $error("ram_we is unknown");

endmodule

// File: verilog/tag_cluster.sv
// tag cluster, a slice of tag entries with valid bits, equality search and highest-index pick
`timescale 1ns/1ns

module tag_cluster
    import cam_size_pkg::*;
    import cam_tag_pkg::*;
#(
    parameter int addr_w       = ADDR_W,
    parameter int tag_w        = TAG_W,
    parameter int cluster_size = CLUSTER_SIZE,
    parameter int base         = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tag_wr,
    input  logic [addr_w-1:0] tag_wr_addr,
    input  logic [tag_w-1:0]  tag_wr_tag,
    input  logic [tag_w-1:0]  search_tag,
    output logic              hit,
    output logic [addr_w-1:0] hit_addr
);

    localparam int idx_w = (cluster_size > 1) ? $clog2(cluster_size) : 1;

    logic [tag_w-1:0]        tags [cluster_size];
    logic [cluster_size-1:0] valid;

    logic              wr_sel;
    logic [addr_w-1:0] wr_off;
    logic [idx_w-1:0]  wr_idx;

    logic              match_any;
    logic [idx_w-1:0]  match_idx;

    // own range is [base, base + cluster_size)
    assign wr_sel = tag_wr
                    && (int'(tag_wr_addr) >= base)
                    && (int'(tag_wr_addr) < base + cluster_size);
    assign wr_off = tag_wr_addr - addr_w'(base);
    assign wr_idx = wr_off[idx_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_sel) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_sel) begin
            tags[wr_idx] <= tag_wr_tag;
        end
    end

    // ascending scan, so the last match is the highest index
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        for (int j = 0; j < cluster_size; j++) begin
            if (valid[j] && (tags[j] == search_tag)) begin
                match_any = 1'b1;
                match_idx = idx_w'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= match_any;
        end
    end

    // zero when nothing matched, the merger relies on it
    always_ff @(posedge clk) begin
        if (match_any) begin
            hit_addr <= addr_w'(base) + addr_w'(match_idx);
        end else begin
            hit_addr <= '0;
        end
    end

    a_hit_in_range: assert property (
        @(posedge clk) disable iff (rst)
        hit |-> (int'(hit_addr) >= base) && (int'(hit_addr) < base + cluster_size)
    ) else $error("hit_addr %0d outside cluster at base %0d", hit_addr, base);

endmodule

// File: verilog/match_merge.sv
// match merger, combines cluster hits into one highest-address match and registers the outputs
`timescale 1ns/1ns

module match_merge
    import cam_size_pkg::*;
#(
    parameter int addr_w     = ADDR_W,
    parameter int n_clusters = N_CLUSTERS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [n_clusters-1:0]            hit,
    input  logic [n_clusters-1:0][addr_w-1:0] hit_addr,
    output logic                             cam_match,
    output logic [addr_w-1:0]                cam_match_addr
);

    logic              pick_hit;
    logic [addr_w-1:0] pick_addr;

    logic              merged_hit;
    logic [addr_w-1:0] merged_addr;

    // clusters are ordered by address, highest hitting one wins
    always_comb begin
        pick_hit  = 1'b0;
        pick_addr = '0;
        for (int c = 0; c < n_clusters; c++) begin
            if (hit[c]) begin
                pick_hit  = 1'b1;
                pick_addr = hit_addr[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            merged_hit  <= 1'b0;
            merged_addr <= '0;
        end else begin
            merged_hit  <= pick_hit;
            merged_addr <= pick_addr;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            cam_match      <= 1'b0;
            cam_match_addr <= '0;
        end else begin
            cam_match      <= merged_hit;
            cam_match_addr <= merged_addr;
        end
    end

    a_addr_zero_on_miss: assert property (
        @(posedge clk) disable iff (rst)
        !cam_match |-> (cam_match_addr == '0)
    ) else $error("cam_match_addr %0d without a match", cam_match_addr);

endmodule

// File: verilog/ram_cam_top.sv
// ram cam top, data ram with a clustered parallel tag search and a merged match result
`timescale 1ns/1ns

module ram_cam_top
    import cam_size_pkg::*;
    import cam_tag_pkg::*;
#(
    parameter int data_w       = DATA_W,
    parameter int addr_w       = ADDR_W,
    parameter int tag_w        = TAG_W,
    parameter int cluster_size = CLUSTER_SIZE
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ram_we,
    input  logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_din,
    output logic [data_w-1:0] ram_dout,
    input  logic [tag_w-1:0]  cam_tag,
    output logic              cam_match,
    output logic [addr_w-1:0] cam_match_addr
);

    localparam int n_clusters = (1 << addr_w) / cluster_size;

    // write port broadcast
    logic              tag_wr;
    logic [addr_w-1:0] tag_wr_addr;
    logic [tag_w-1:0]  tag_wr_tag;
    logic [tag_w-1:0]  search_tag;

    // per-cluster results
    logic [n_clusters-1:0]             clu_hit;
    logic [n_clusters-1:0][addr_w-1:0] clu_hit_addr;

    cam_write_port #(
        .data_w (data_w),
        .addr_w (addr_w),
        .tag_w  (tag_w)
    ) write_port_i (
        .clk         (clk),
        .rst         (rst),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_din     (ram_din),
        .cam_tag     (cam_tag),
        .ram_dout    (ram_dout),
        .tag_wr      (tag_wr),
        .tag_wr_addr (tag_wr_addr),
        .tag_wr_tag  (tag_wr_tag),
        .search_tag  (search_tag)
    );

    for (genvar c = 0; c < n_clusters; c++) begin : g_cluster
        tag_cluster #(
            .addr_w       (addr_w),
            .tag_w        (tag_w),
            .cluster_size (cluster_size),
            .base         (c * cluster_size)
        ) cluster_i (
            .clk         (clk),
            .rst         (rst),
            .tag_wr      (tag_wr),
            .tag_wr_addr (tag_wr_addr),
            .tag_wr_tag  (tag_wr_tag),
            .search_tag  (search_tag),
            .hit         (clu_hit[c]),
            .hit_addr    (clu_hit_addr[c])
        );
    end

    match_merge #(
        .addr_w     (addr_w),
        .n_clusters (n_clusters)
    ) merge_i (
        .clk            (clk),
        .rst            (rst),
        .hit            (clu_hit),
        .hit_addr       (clu_hit_addr),
        .cam_match      (cam_match),
        .cam_match_addr (cam_match_addr)
    );

endmodule

// File: testbench/ram_cam_model.svh
// ram cam reference model, mirrored data, tags and valid bits with the expected results
`ifndef RAM_CAM_MODEL_SVH
`define RAM_CAM_MODEL_SVH

logic [DATA_W-1:0] model_data [DEPTH];
logic [TAG_W-1:0]  model_tag [DEPTH];
logic [DEPTH-1:0]  model_valid = '0;
// ram words written since time zero, the ram itself has no reset
logic [DEPTH-1:0]  model_known = '0;

function automatic void model_reset();
    model_valid = '0;
endfunction

// the tag is the top TAG_W bits of the word
function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] din);
    model_data[addr]  = din;
    model_tag[addr]   = din[DATA_W-1:TAG_LSB];
    model_valid[addr] = 1'b1;
    model_known[addr] = 1'b1;
endfunction

function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
    return model_data[addr];
endfunction

function automatic logic expect_match(input logic [TAG_W-1:0] tag);
    logic found;
    found = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
        if (model_valid[i] && (model_tag[i] == tag)) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

// descending scan, first hit is the highest address
function automatic logic [ADDR_W-1:0] expect_match_addr(input logic [TAG_W-1:0] tag);
    logic [ADDR_W-1:0] addr;
    logic              found;
    addr  = '0;
    found = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
        if (!found && model_valid[i] && (model_tag[i] == tag)) begin
            found = 1'b1;
            addr  = ADDR_W'(i);
        end
    end
    return addr;
endfunction

`endif

// File: testbench/ram_cam_tb.sv
// ram cam testbench, drives writes, reads and searches and checks them against a model
`timescale 1ns/1ns

module ram_cam_tb
    import cam_size_pkg::*;
    import cam_tag_pkg::*;
();

    localparam int max_cycles    = 3000;
    localparam int random_cycles = 1200;
    localparam int read_latency  = 2;
    localparam int search_latency = 4;

    localparam logic [TAG_W-1:0] dup_tag   = 16'hbeef;
    localparam logic [TAG_W-1:0] other_tag = 16'h1234;

    logic              clk;
    logic              rst;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_din;
    logic [DATA_W-1:0] ram_dout;
    logic [TAG_W-1:0]  cam_tag;
    logic              cam_match;
    logic [ADDR_W-1:0] cam_match_addr;

    integer seed;
    int     cyc = 0;
    int     checks = 0;
    int     read_errors = 0;
    int     search_errors = 0;

    // expected results, each tagged with the cycle it is due
    int                rd_due_q [$];
    logic [ADDR_W-1:0] rd_addr_q [$];
    logic [DATA_W-1:0] rd_exp_q [$];
    int                sr_due_q [$];
    logic [TAG_W-1:0]  sr_tag_q [$];
    logic              sr_match_q [$];
    logic [ADDR_W-1:0] sr_addr_q [$];

    logic [TAG_W-1:0]  tag_pool [8];

    `include "ram_cam_model.svh"

    ram_cam_top #(
        .data_w       (DATA_W),
        .addr_w       (ADDR_W),
        .tag_w        (TAG_W),
        .cluster_size (CLUSTER_SIZE)
    ) ram_cam_top_i (
        .clk            (clk),
        .rst            (rst),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .ram_dout       (ram_dout),
        .cam_tag        (cam_tag),
        .cam_match      (cam_match),
        .cam_match_addr (cam_match_addr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (cyc >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [DATA_W-1:0] word_with_tag(input logic [TAG_W-1:0] tag);
        logic [31:0] r;
        r = next_random();
        return {tag, r[TAG_LSB-1:0]};
    endfunction

    // one cycle of inputs; a search sees only writes of earlier cycles
    task automatic drive_cycle(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] din, input logic [TAG_W-1:0] tag);
        @(posedge clk);
        #1;
        ram_we   = we;
        ram_addr = addr;
        ram_din  = din;
        cam_tag  = tag;
        sr_due_q.push_back(cyc + search_latency);
        sr_tag_q.push_back(tag);
        sr_match_q.push_back(expect_match(tag));
        sr_addr_q.push_back(expect_match_addr(tag));
        if (!we && model_known[addr]) begin
            rd_due_q.push_back(cyc + read_latency);
            rd_addr_q.push_back(addr);
            rd_exp_q.push_back(expect_read(addr));
        end
        if (we) begin
            model_write(addr, din);
        end
    endtask

    task automatic write_entry(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] din);
        drive_cycle(1'b1, addr, din, '0);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        drive_cycle(1'b0, addr, '0, '0);
    endtask

    task automatic search_for(input logic [TAG_W-1:0] tag);
        drive_cycle(1'b0, '0, '0, tag);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        while (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
            if (ram_dout !== rd_exp_q[0]) begin
                $display("Fail at %0t ns: ram_dout got %h expected %h (addr %0d)",
                         $time, ram_dout, rd_exp_q[0], rd_addr_q[0]);
                read_errors++;
            end
            checks++;
            void'(rd_due_q.pop_front());
            void'(rd_addr_q.pop_front());
            void'(rd_exp_q.pop_front());
        end
        while (sr_due_q.size() > 0 && sr_due_q[0] == cyc) begin
            if (cam_match !== sr_match_q[0]) begin
                $display("Fail at %0t ns: cam_match got %b expected %b (tag %h)",
                         $time, cam_match, sr_match_q[0], sr_tag_q[0]);
                search_errors++;
            end
            if (cam_match_addr !== sr_addr_q[0]) begin
                $display("Fail at %0t ns: cam_match_addr got %0d expected %0d (tag %h)",
                         $time, cam_match_addr, sr_addr_q[0], sr_tag_q[0]);
                search_errors++;
            end
            checks++;
            void'(sr_due_q.pop_front());
            void'(sr_tag_q.pop_front());
            void'(sr_match_q.pop_front());
            void'(sr_addr_q.pop_front());
        end
    end

    initial begin
        logic [31:0]       r;
        logic [31:0]       s;
        logic [TAG_W-1:0]  wtag;
        logic [TAG_W-1:0]  stag;
        logic [TAG_W-1:0]  dist_tag;
        seed     = 32'h2dee_b222;
        rst      = 1'b1;
        ram_we   = 1'b0;
        ram_addr = '0;
        ram_din  = '0;
        cam_tag  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        model_reset();

        // empty array after reset
        search_for('0);
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            search_for(r[TAG_W-1:0]);
        end

        // fill the ram, then read it all back
        for (int a = 0; a < DEPTH; a++) begin
            r = next_random();
            drive_cycle(1'b1, ADDR_W'(a), r[DATA_W-1:0], r[31 -: TAG_W]);
        end
        for (int a = 0; a < DEPTH; a++) begin
            read_word(ADDR_W'(a));
        end

        // one distinct tag per entry
        for (int a = 0; a < DEPTH; a++) begin
            dist_tag = TAG_W'(a * 37 + 1000);
            write_entry(ADDR_W'(a), word_with_tag(dist_tag));
        end
        for (int a = 0; a < DEPTH; a++) begin
            dist_tag = TAG_W'(a * 37 + 1000);
            search_for(dist_tag);
        end

        // duplicates across clusters, then inside cluster 2
        write_entry(ADDR_W'(3), word_with_tag(dup_tag));
        write_entry(ADDR_W'(20), word_with_tag(dup_tag));
        write_entry(ADDR_W'(41), word_with_tag(dup_tag));
        search_for(dup_tag);
        write_entry(ADDR_W'(44), word_with_tag(dup_tag));
        write_entry(ADDR_W'(42), word_with_tag(dup_tag));
        search_for(dup_tag);
        // overwrite of the top hit, the old tag must move down to 42
        write_entry(ADDR_W'(44), word_with_tag(other_tag));
        search_for(dup_tag);
        search_for(other_tag);
        write_entry(ADDR_W'(5), word_with_tag(dup_tag));
        search_for(dup_tag);

        // small tag pool so that random searches hit and entries get overwritten
        for (int k = 0; k < 8; k++) begin
            r = next_random();
            tag_pool[k] = r[TAG_W-1:0];
        end
        for (int n = 0; n < random_cycles; n++) begin
            r = next_random();
            s = next_random();
            wtag = s[3] ? tag_pool[s[2:0]] : s[31 -: TAG_W];
            stag = (s[7:6] != 2'b00) ? tag_pool[s[10:8]] : r[31 -: TAG_W];
            drive_cycle(r[9:7] < 3'd3, r[ADDR_W-1:0], {wtag, s[TAG_LSB+15:16]}, stag);
        end

        @(posedge clk);
        #1;
        ram_we = 1'b0;
        while (rd_due_q.size() != 0 || sr_due_q.size() != 0) begin
            @(posedge clk);
        end

        $display("Checks: %0d, read errors: %0d, search errors: %0d",
                 checks, read_errors, search_errors);
        if (read_errors + search_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
verilog/cam_size_pkg.sv
verilog/cam_tag_pkg.sv
verilog/cam_write_port.sv
verilog/tag_cluster.sv
verilog/match_merge.sv
verilog/ram_cam_top.sv
testbench/ram_cam_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ram cam testbench with verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f build.f --top-module ram_cam_tb \
    --Mdir "$build_dir" -o ram_cam_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/ram_cam_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$log_file"; then
    exit 1
fi
if ! grep -q "Test passed" "$log_file"; then
    echo "simulation log holds no result line"
    exit 1
fi
exit 0
